// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f project.f --top-module ctrlUnitTb
	@out="$$(./obj_dir/VctrlUnitTb)"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== common/ctrlPkg.sv ====
`include "ctrl_config.svh"

package ctrlPkg;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opcRType = 6'b000000,
        opcBeq   = 6'b000100,
        opcBne   = 6'b000101,
        opcBle   = 6'b000110,
        opcBgt   = 6'b000111,
        opcAddi  = 6'b001000,
        opcAddiu = 6'b001001
    } opcode_t;

    typedef enum logic [`FUNCT_WIDTH-1:0] {
        fnMfhi = 6'b010000,
        fnMflo = 6'b010010,
        fnMult = 6'b011000,
        fnDiv  = 6'b011010,
        fnAdd  = 6'b100000,
        fnSub  = 6'b100010,
        fnAnd  = 6'b100100
    } funct_t;

    // Raw fields, so unknown encodings stay representable
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0] opcode;
        logic [`FUNCT_WIDTH-1:0]  funct;
    } instrFields_t;

    typedef enum logic [3:0] {
        opAdd, opSub, opAnd, opAddi, opAddiu,
        opBeq, opBne, opBle, opBgt,
        opMult, opDiv, opMfhi, opMflo,
        opIllegal
    } op_t;

    typedef enum logic [4:0] {
        stInit, stFetch, stPrecalc, stLoadOperands,
        stAdd, stSub, stAnd, stAddi, stAddiu,
        stWriteRd, stWriteRt,
        stBeq, stBne, stBle, stBgt, stBranchTaken,
        stMultStart, stMultWait, stMultResult,
        stDivStart, stDivWait, stDivResult,
        stMfhi, stMflo,
        stTrap
    } state_t;

    typedef struct packed {
        logic overflow;
        logic gt;
        logic lt;
        logic eq;
    } aluFlags_t;

    typedef enum logic [2:0] {
        aluNone    = 3'b000,
        aluAdd     = 3'b001,
        aluSub     = 3'b010,
        aluAnd     = 3'b011,
        aluCompare = 3'b111
    } aluOp_t;

    typedef enum logic [1:0] {srcAPc = 2'b00, srcARegA = 2'b01} aluSrcA_t;

    typedef enum logic [1:0] {
        srcBRegB         = 2'b00,
        srcBFour         = 2'b01,
        srcBBranchOffset = 2'b10,
        srcBSignImm      = 2'b11
    } aluSrcB_t;

    typedef enum logic [1:0] {pcPlus4 = 2'b00, pcAluOut = 2'b10} pcSrc_t;

    typedef enum logic [1:0] {dstRd = 2'b00, dstStackReg = 2'b01, dstRt = 2'b11} regDst_t;

    typedef enum logic [1:0] {
        dataAluOut   = 2'b00,
        dataLo       = 2'b01,
        dataHi       = 2'b10,
        dataStackTop = 2'b11
    } regData_t;

    typedef struct packed {
        logic     writePc;
        logic     writeA;
        logic     writeB;
        logic     writeAluOut;
        logic     writeInstr;
        logic     writeReg;
        logic     writeHiLo;
        logic     hiLoSel;     // 0 mult result, 1 div result
        logic     multStart;
        logic     divStart;
        aluOp_t   aluOp;
        aluSrcA_t aluSrcA;
        aluSrcB_t aluSrcB;
        pcSrc_t   pcSrc;
        regDst_t  regDst;
        regData_t regData;
    } ctrlWord_t;

    typedef enum logic [1:0] {trapNone, trapBadOpcode, trapOverflow} trap_t;

endpackage

// ==== common/ctrl_config.svh ====
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// Instruction field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6

// Fetch sequencing
`define STEP_WIDTH 2
`define FETCH_STEPS 4 // Memory read takes three cycles, PC update one

`endif

// ==== project.f ====
+incdir+common
common/ctrlPkg.sv
src/instrDecoder.sv
sequencer/stateSequencer.sv
sequencer/controlWordGen.sv
src/ctrlUnit.sv
testbench/ctrlUnitTb.sv

// ==== sequencer/controlWordGen.sv ====
`timescale 1ns/100ps
`include "ctrl_config.svh"

module controlWordGen import ctrlPkg::*; (
    input  state_t                 state,
    input  logic [`STEP_WIDTH-1:0] step,
    output ctrlWord_t              ctrl
);

    localparam ctrlWord_t ctrlIdle = '{
        writePc:     1'b0,
        writeA:      1'b0,
        writeB:      1'b0,
        writeAluOut: 1'b0,
        writeInstr:  1'b0,
        writeReg:    1'b0,
        writeHiLo:   1'b0,
        hiLoSel:     1'b0,
        multStart:   1'b0,
        divStart:    1'b0,
        aluOp:       aluNone,
        aluSrcA:     srcAPc,
        aluSrcB:     srcBRegB,
        pcSrc:       pcPlus4,
        regDst:      dstRd,
        regData:     dataAluOut
    };

    always_comb begin
        ctrl = ctrlIdle;
        case (state)
            stInit: begin
                ctrl.writeReg = 1'b1; // Load stack pointer
                ctrl.regDst   = dstStackReg;
                ctrl.regData  = dataStackTop;
            end
            stFetch: begin
                if (int'(step) == `FETCH_STEPS - 1) begin
                    ctrl.writePc = 1'b1; // PC takes pc + 4
                    ctrl.pcSrc   = pcAluOut;
                end else begin
                    ctrl.writeInstr  = 1'b1;
                    ctrl.writeAluOut = 1'b1;
                    ctrl.aluSrcA     = srcAPc;
                    ctrl.aluSrcB     = srcBFour;
                    ctrl.aluOp       = aluAdd;
                end
            end
            stPrecalc: begin
                ctrl.writeAluOut = 1'b1; // Branch target into ALUOut
                ctrl.aluSrcA     = srcAPc;
                ctrl.aluSrcB     = srcBBranchOffset;
                ctrl.aluOp       = aluAdd;
            end
            stLoadOperands: begin
                ctrl.writeA = 1'b1;
                ctrl.writeB = 1'b1;
            end
            stAdd, stSub, stAnd: begin
                ctrl.writeAluOut = 1'b1;
                ctrl.aluSrcA     = srcARegA;
                ctrl.aluSrcB     = srcBRegB;
                case (state)
                    stSub:   ctrl.aluOp = aluSub;
                    stAnd:   ctrl.aluOp = aluAnd;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            stAddi, stAddiu: begin
                ctrl.writeAluOut = 1'b1;
                ctrl.aluSrcA     = srcARegA;
                ctrl.aluSrcB     = srcBSignImm;
                ctrl.aluOp       = aluAdd;
            end
            stWriteRd: begin
                ctrl.writeReg = 1'b1;
                ctrl.regDst   = dstRd;
                ctrl.regData  = dataAluOut;
            end
            stWriteRt: begin
                ctrl.writeReg = 1'b1;
                ctrl.regDst   = dstRt;
                ctrl.regData  = dataAluOut;
            end
            stBeq, stBne, stBle, stBgt: begin
                ctrl.aluSrcA = srcARegA;
                ctrl.aluSrcB = srcBRegB;
                ctrl.aluOp   = aluCompare;
            end
            stBranchTaken: begin
                ctrl.writePc = 1'b1;
                ctrl.pcSrc   = pcAluOut;
            end
            stMultStart:  ctrl.multStart = 1'b1;
            stDivStart:   ctrl.divStart  = 1'b1;
            stMultResult: ctrl.writeHiLo = 1'b1;
            stDivResult: begin
                ctrl.writeHiLo = 1'b1;
                ctrl.hiLoSel   = 1'b1;
            end
            stMfhi: begin
                ctrl.writeReg = 1'b1;
                ctrl.regDst   = dstRd;
                ctrl.regData  = dataHi;
            end
            stMflo: begin
                ctrl.writeReg = 1'b1;
                ctrl.regDst   = dstRd;
                ctrl.regData  = dataLo;
            end
            default: ctrl = ctrlIdle; // Wait states and trap
        endcase
    end

endmodule

// ==== sequencer/stateSequencer.sv ====
`timescale 1ns/100ps
`include "ctrl_config.svh"

module stateSequencer import ctrlPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  op_t                    op,
    input  aluFlags_t              flags,
    input  logic                   multDone,
    input  logic                   divDone,
    output state_t                 state,
    output logic [`STEP_WIDTH-1:0] step,
    output trap_t                  trap
);

    state_t nextState;
    trap_t  nextTrap;
    logic   lastStep;

    assign lastStep = (int'(step) == `FETCH_STEPS - 1);

    always_comb begin
        nextState = state;
        nextTrap  = trap; // Cause is held once set
        case (state)
            stInit:    nextState = stFetch;
            stFetch: begin
                if (lastStep) begin
                    nextState = stPrecalc;
                end
            end
            stPrecalc: nextState = stLoadOperands;

            // Dispatch on the decoded op while the instruction register holds it
            stLoadOperands: begin
                case (op)
                    opAdd:   nextState = stAdd;
                    opSub:   nextState = stSub;
                    opAnd:   nextState = stAnd;
                    opAddi:  nextState = stAddi;
                    opAddiu: nextState = stAddiu;
                    opBeq:   nextState = stBeq;
                    opBne:   nextState = stBne;
                    opBle:   nextState = stBle;
                    opBgt:   nextState = stBgt;
                    opMult:  nextState = stMultStart;
                    opDiv:   nextState = stDivStart;
                    opMfhi:  nextState = stMfhi;
                    opMflo:  nextState = stMflo;
                    default: begin
                        nextState = stTrap;
                        nextTrap  = trapBadOpcode;
                    end
                endcase
            end

            stAdd, stSub: begin
                if (flags.overflow) begin
                    nextState = stTrap;
                    nextTrap  = trapOverflow;
                end else begin
                    nextState = stWriteRd;
                end
            end
            stAnd: nextState = stWriteRd;
            stAddi: begin
                if (flags.overflow) begin
                    nextState = stTrap;
                    nextTrap  = trapOverflow;
                end else begin
                    nextState = stWriteRt;
                end
            end
            stAddiu: nextState = stWriteRt; // Unsigned add never traps
            stWriteRd, stWriteRt: nextState = stFetch;

            // Compare result is valid in the branch state itself
            stBeq: nextState = flags.eq ? stBranchTaken : stFetch;
            stBne: nextState = !flags.eq ? stBranchTaken : stFetch;
            stBle: nextState = (flags.eq || flags.lt) ? stBranchTaken : stFetch;
            stBgt: nextState = flags.gt ? stBranchTaken : stFetch;
            stBranchTaken: nextState = stFetch;

            stMultStart: nextState = stMultWait;
            stMultWait: begin
                if (multDone) begin
                    nextState = stMultResult;
                end
            end
            stMultResult: nextState = stFetch;
            stDivStart:   nextState = stDivWait;
            stDivWait: begin
                if (divDone) begin
                    nextState = stDivResult;
                end
            end
            stDivResult: nextState = stFetch;

            stMfhi, stMflo: nextState = stFetch;
            stTrap:         nextState = stTrap; // Only reset leaves
            default:        nextState = stTrap;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stInit;
            step  <= '0;
            trap  <= trapNone;
        end else begin
            state <= nextState;
            trap  <= nextTrap;
            if (state == stFetch && !lastStep) begin
                step <= step + 1'b1;
            end else begin
                step <= '0;
            end
        end
    end

endmodule

// ==== src/ctrlUnit.sv ====
`timescale 1ns/100ps
`include "ctrl_config.svh"

module ctrlUnit import ctrlPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  instrFields_t instr,
    input  aluFlags_t    flags,
    input  logic         multDone,
    input  logic         divDone,
    output ctrlWord_t    ctrl,
    output trap_t        trap
);

    op_t                    op;
    state_t                 state;
    logic [`STEP_WIDTH-1:0] step;

    instrDecoder decoder0 (
        .instr (instr),
        .op    (op)
    );

    stateSequencer sequencer0 (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .flags    (flags),
        .multDone (multDone),
        .divDone  (divDone),
        .state    (state),
        .step     (step),
        .trap     (trap)
    );

    controlWordGen ctrlGen0 (
        .state (state),
        .step  (step),
        .ctrl  (ctrl)
    );

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/100ps
`include "ctrl_config.svh"

module instrDecoder import ctrlPkg::*; (
    input  instrFields_t instr,
    output op_t          op
);

    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`FUNCT_WIDTH-1:0]  funct;

    assign opcode = instr.opcode;
    assign funct  = instr.funct;

    always_comb begin
        case (opcode)
            opcRType: begin
                case (funct)
                    fnAdd:   op = opAdd;
                    fnSub:   op = opSub;
                    fnAnd:   op = opAnd;
                    fnMult:  op = opMult;
                    fnDiv:   op = opDiv;
                    fnMfhi:  op = opMfhi;
                    fnMflo:  op = opMflo;
                    default: op = opIllegal; // Unknown funct
                endcase
            end
            opcAddi:  op = opAddi;
            opcAddiu: op = opAddiu;
            opcBeq:   op = opBeq;
            opcBne:   op = opBne;
            opcBle:   op = opBle;
            opcBgt:   op = opBgt;
            default:  op = opIllegal;
        endcase
    end

endmodule

// ==== testbench/ctrlUnitTb.sv ====
`timescale 1ns/100ps

module ctrlUnitTb import ctrlPkg::*; ();

    typedef enum {
        kAdd, kSub, kAnd, kAddi, kAddiu, kBeq, kBne, kBle, kBgt,
        kMult, kDiv, kMfhi, kMflo, kBadOpcode, kBadFunct
    } instrKind_t;

    localparam logic [8:0] regWriteOnly = 9'b000001000;

    logic         clk;
    logic         reset;
    instrFields_t instr;
    aluFlags_t    flags;
    logic         multDone;
    logic         divDone;
    ctrlWord_t    ctrl;
    trap_t        trap;
    logic [8:0]   activeBits;

    assign activeBits = {ctrl.writePc, ctrl.writeA, ctrl.writeB, ctrl.writeAluOut,
                         ctrl.writeInstr, ctrl.writeReg, ctrl.writeHiLo, ctrl.multStart,
                         ctrl.divStart};

    ctrlUnit dut0 (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .flags    (flags),
        .multDone (multDone),
        .divDone  (divDone),
        .ctrl     (ctrl),
        .trap     (trap)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic showMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        abortRun();
    endtask

    task automatic describeError(input string what);
        $display("Error: %s", what);
        abortRun();
    endtask

    task automatic expectValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else showMismatch(name, got, exp);
    endtask

    // Cause holds until reset, and a trapped unit drives nothing
    assert property (@(posedge clk) disable iff (reset) (trap != trapNone) |=> $stable(trap))
        else describeError("trap cause changed before reset");
    assert property (@(negedge clk) (trap != trapNone) |-> (activeBits == '0))
        else showMismatch("activeBits", 32'(activeBits), 32'h0);

    function automatic instrFields_t encode(input instrKind_t kind);
        instrFields_t f;
        f.opcode = opcRType;
        f.funct  = fnAdd;
        case (kind)
            kSub:       f.funct = fnSub;
            kAnd:       f.funct = fnAnd;
            kMult:      f.funct = fnMult;
            kDiv:       f.funct = fnDiv;
            kMfhi:      f.funct = fnMfhi;
            kMflo:      f.funct = fnMflo;
            kBadFunct:  f.funct = 6'b000001;
            kAddi:      f.opcode = opcAddi;
            kAddiu:     f.opcode = opcAddiu;
            kBeq:       f.opcode = opcBeq;
            kBne:       f.opcode = opcBne;
            kBle:       f.opcode = opcBle;
            kBgt:       f.opcode = opcBgt;
            kBadOpcode: f.opcode = 6'b111111;
            default:    ;
        endcase
        return f;
    endfunction

    function automatic logic isAluKind(input instrKind_t kind);
        return kind inside {kAdd, kSub, kAnd, kAddi, kAddiu};
    endfunction

    function automatic logic branchTaken(input instrKind_t kind, input aluFlags_t fl);
        case (kind)
            kBeq:    return fl.eq;
            kBne:    return !fl.eq;
            kBle:    return fl.eq || fl.lt;
            kBgt:    return fl.gt;
            default: return 1'b0;
        endcase
    endfunction

    function automatic trap_t expectedTrap(input instrKind_t kind, input aluFlags_t fl);
        if (kind inside {kBadOpcode, kBadFunct}) return trapBadOpcode;
        if (kind inside {kAdd, kSub, kAddi} && fl.overflow) return trapOverflow;
        return trapNone;
    endfunction

    task automatic checkInitCycle();
        @(negedge clk);
        expectValue("activeBits", 32'(activeBits), 32'(regWriteOnly)); // Only the SP write
        expectValue("regDst", 32'(ctrl.regDst), 32'(dstStackReg));
        expectValue("regData", 32'(ctrl.regData), 32'(dataStackTop));
        expectValue("trap", 32'(trap), 32'(trapNone));
        @(negedge clk);
        expectValue("writeInstr", 32'(ctrl.writeInstr), 32'h1);
        expectValue("writeReg", 32'(ctrl.writeReg), 32'h0);
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        checkInitCycle();
    endtask

    // Runs from the first fetch cycle of one instruction to that of the next
    task automatic runInstr(input instrKind_t kind, input aluFlags_t fl);
        trap_t expTrap;
        logic  taken;
        logic  finished;
        int    idx, countdown, doneIdx, compareIdx, expCycles;
        int    regWrites, execCycles, pcWrites, starts, hiLoWrites;
        expTrap = expectedTrap(kind, fl);
        taken = branchTaken(kind, fl);
        idx = 0;
        countdown = 0;
        doneIdx = 0;
        compareIdx = 0;
        regWrites = 0;
        execCycles = 0;
        pcWrites = 0;
        starts = 0;
        hiLoWrites = 0;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk);
            #1;
            if (idx == 0) begin
                instr = encode(kind);
                flags = fl;
                multDone = 1'b0;
                divDone = 1'b0;
            end
            if (countdown > 0) begin
                countdown--;
                if (countdown == 0) begin
                    if (kind == kMult) multDone = 1'b1;
                    else divDone = 1'b1;
                    doneIdx = idx + 1;
                end
            end
            @(negedge clk);
            idx++;
            if (idx > 100) describeError($sformatf("timeout in %s", kind.name()));
            if (idx <= 2) begin
                expectValue("writeInstr", 32'(ctrl.writeInstr), 32'h1);
                expectValue("writeAluOut", 32'(ctrl.writeAluOut), 32'h1);
                expectValue("aluSrcA", 32'(ctrl.aluSrcA), 32'(srcAPc));
                expectValue("aluSrcB", 32'(ctrl.aluSrcB), 32'(srcBFour));
                expectValue("aluOp", 32'(ctrl.aluOp), 32'(aluAdd));
            end
            if (idx == 3) begin
                expectValue("writeInstr", 32'(ctrl.writeInstr), 32'h0);
                expectValue("writePc", 32'(ctrl.writePc), 32'h1);
                expectValue("pcSrc", 32'(ctrl.pcSrc), 32'(pcAluOut));
            end
            if (idx == 4) begin
                expectValue("writeAluOut", 32'(ctrl.writeAluOut), 32'h1);
                expectValue("aluSrcB", 32'(ctrl.aluSrcB), 32'(srcBBranchOffset));
            end
            if (idx == 5) begin
                expectValue("writeA", 32'(ctrl.writeA), 32'h1);
                expectValue("writeB", 32'(ctrl.writeB), 32'h1);
            end
            if (ctrl.writeReg) begin
                regWrites++;
                expectValue("regDst", 32'(ctrl.regDst),
                            kind inside {kAddi, kAddiu} ? 32'(dstRt) : 32'(dstRd));
                expectValue("regData", 32'(ctrl.regData), kind == kMfhi ? 32'(dataHi) :
                            kind == kMflo ? 32'(dataLo) : 32'(dataAluOut));
            end
            if (ctrl.writeAluOut && ctrl.aluSrcA == srcARegA) begin
                execCycles++;
                expectValue("aluOp", 32'(ctrl.aluOp), kind == kSub ? 32'(aluSub) :
                            kind == kAnd ? 32'(aluAnd) : 32'(aluAdd));
                expectValue("aluSrcB", 32'(ctrl.aluSrcB),
                            kind inside {kAddi, kAddiu} ? 32'(srcBSignImm) : 32'(srcBRegB));
            end
            if (ctrl.aluOp == aluCompare) compareIdx = idx;
            if (idx > 3 && ctrl.writePc) begin
                pcWrites++;
                expectValue("pcSrc", 32'(ctrl.pcSrc), 32'(pcAluOut));
                expectValue("compareIdx", compareIdx, idx - 1); // Right after the compare
            end
            if (ctrl.multStart || ctrl.divStart) begin
                starts++;
                expectValue("multStart", 32'(ctrl.multStart), 32'(kind == kMult));
                expectValue("divStart", 32'(ctrl.divStart), 32'(kind == kDiv));
                countdown = $urandom_range(20, 1);
            end
            if (ctrl.writeHiLo) begin
                hiLoWrites++;
                assert (doneIdx > 0 && idx == doneIdx + 1)
                    else describeError("writeHiLo not in the cycle after done");
                expectValue("hiLoSel", 32'(ctrl.hiLoSel), 32'(kind == kDiv));
            end
            if ((idx > 3 && ctrl.writeInstr) || trap != trapNone) finished = 1'b1;
        end
        expectValue("trap", 32'(trap), 32'(expTrap));
        expectValue("regWrites", regWrites, (expTrap == trapNone &&
                    (isAluKind(kind) || kind inside {kMfhi, kMflo})) ? 1 : 0);
        expectValue("execCycles", execCycles, isAluKind(kind) ? 1 : 0);
        expectValue("pcWrites", pcWrites, taken ? 1 : 0);
        expectValue("starts", starts, kind inside {kMult, kDiv} ? 1 : 0);
        expectValue("hiLoWrites", hiLoWrites, kind inside {kMult, kDiv} ? 1 : 0);
        if (expTrap != trapNone) begin
            repeat (20) begin
                @(negedge clk);
                expectValue("activeBits", 32'(activeBits), 32'h0);
            end
            applyReset();
        end else begin
            expCycles = isAluKind(kind) ? 8 : kind inside {kMfhi, kMflo} ? 7 :
                        kind inside {kBeq, kBne, kBle, kBgt} ? (taken ? 8 : 7) : 0;
            if (expCycles > 0) expectValue("cycles", idx, expCycles);
        end
    endtask

    initial begin
        instrKind_t branchKinds[4];
        aluFlags_t  branchFlags[3];
        branchKinds = '{kBeq, kBne, kBle, kBgt};
        branchFlags = '{4'b0001, 4'b0000, 4'b0100}; // eq, none, gt
        void'($urandom(32'hb963));
        reset = 1'b1;
        instr = encode(kAdd);
        flags = '0;
        multDone = 1'b0;
        divDone = 1'b0;
        applyReset();

        runInstr(kAdd, '0);
        runInstr(kSub, '0);
        runInstr(kAnd, '0);
        runInstr(kAddi, '0);
        runInstr(kAddiu, '0);
        runInstr(kAnd, 4'b1000); // Overflow ignored
        runInstr(kAddiu, 4'b1000);
        runInstr(kAdd, 4'b1000);
        runInstr(kSub, 4'b1000);
        runInstr(kAddi, 4'b1000);

        foreach (branchKinds[k]) begin
            foreach (branchFlags[f]) runInstr(branchKinds[k], branchFlags[f]);
            repeat (6) runInstr(branchKinds[k], 4'($urandom));
        end

        repeat (4) begin
            runInstr(kMult, '0);
            runInstr(kDiv, '0);
        end
        runInstr(kMfhi, '0);
        runInstr(kMflo, '0);
        runInstr(kBadOpcode, '0);
        runInstr(kBadFunct, '0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
